// ==== source/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// word and memory geometry
`define DATA_SIZE 32
`define ADDR_SIZE 10
`define MEM_DEPTH 1024

// register file layout
`define REG_NUM_SIZE 4
`define REG_COUNT 16

// register 15 doubles as the instruction pointer
`define REG_IP 15

// first command word after reset
`define PROG_START 64

`endif

// ==== source/cpu_pkg.sv ====
`include "cpu_defs.svh"

package cpu_pkg;

  typedef logic [`DATA_SIZE-1:0] dataT;
  typedef logic [`ADDR_SIZE-1:0] addrT;
  typedef logic [`REG_NUM_SIZE-1:0] regNumT;
  typedef logic [1:0] flagsT;

  typedef enum logic [3:0] {
    ADD  = 4'h0,
    SUB  = 4'h1,
    AND  = 4'h2,
    OR   = 4'h3,
    XOR  = 4'h4,
    PASS = 4'h5,
    HALT = 4'hF
  } opT;

  typedef enum logic [4:0] {
    WAIT_FOR_START, FETCH, PREEXECUTE, WRITE_REG_IP,
    READ_COND, READ_COND_P, READ_SRC1, READ_SRC1_P, READ_SRC0, READ_SRC0_P,
    ALU_BEGIN, WRITE_PREP, WRITE_DST, WRITE_DST_P,
    WRITE_COND, WRITE_SRC1, WRITE_SRC0, FINISH, HALTED
  } stateT;

  // command word fields, msb first
  typedef struct packed {
    opT     op;
    flagsT  cndFlags;
    flagsT  dFlags;
    flagsT  s0Flags;
    flagsT  s1Flags;
    logic   cndPtr;
    logic   dPtr;
    logic   s0Ptr;
    logic   s1Ptr;
    regNumT cnd;
    regNumT d;
    regNumT s0;
    regNumT s1;
  } cmdT;

endpackage

// ==== source/StateManager.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module StateManager import cpu_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  start,
  input  dataT  command,
  input  dataT  cond,
  input  logic  stepDone,
  output stateT state,
  output logic  isIpSaveAllowed,
  output logic  isDSaveAllowed,
  output logic  isDSavePtrAllowed,
  output logic  isCndSaveAllowed,
  output logic  isS1SaveAllowed,
  output logic  isS0SaveAllowed
);
  cmdT   c;
  logic  condOk;
  logic  dRegWrite;
  logic  ipWriteBack;
  logic  ipFirst;
  logic  ipWritten;
  logic  condRead;
  logic  advance;
  stateT afterCond;
  stateT nextState;

  // next operand state, stage 0 = cond, 1 = s1, 2 = s0, 3 = alu
  function automatic stateT operandFrom(input logic [1:0] stage);
    stateT next;
    next = ALU_BEGIN;
    if (stage <= 2'd2 && !(&c.s0Flags))
      next = READ_SRC0;
    if (stage <= 2'd1 && !(&c.s1Flags))
      next = READ_SRC1;
    if (stage == 2'd0 && !(&c.cndFlags))
      next = READ_COND;
    return next;
  endfunction

  // next write state, stage 0 = dst, 1 = cond, 2 = s1, 3 = s0
  function automatic stateT writeFrom(input logic [1:0] stage);
    stateT next;
    next = FINISH;
    if (isS0SaveAllowed)
      next = WRITE_SRC0;
    if (stage <= 2'd2 && isS1SaveAllowed)
      next = WRITE_SRC1;
    if (stage <= 2'd1 && isCndSaveAllowed)
      next = WRITE_COND;
    if (stage == 2'd0 && isDSavePtrAllowed)
      next = WRITE_DST_P;
    if (stage == 2'd0 && isDSaveAllowed)
      next = WRITE_DST;
    return next;
  endfunction

  assign c = cmdT'(command);
  assign condOk = (&c.cndFlags) || (cond != '0);
  assign dRegWrite = !(&c.dFlags) && !c.dPtr;
  assign ipWriteBack = (^c.cndFlags && c.cnd == `REG_IP) ||
                       (^c.s1Flags && c.s1 == `REG_IP) ||
                       (^c.s0Flags && c.s0 == `REG_IP);

  assign isDSaveAllowed = dRegWrite && condOk;
  assign isDSavePtrAllowed = !(&c.dFlags) && c.dPtr && condOk;
  assign isIpSaveAllowed = !((isDSaveAllowed && c.d == `REG_IP) || ipWriteBack);
  // write priority is D, then Cnd, then S1, then S0
  assign isCndSaveAllowed = ^c.cndFlags && (c.d != c.cnd || !isDSaveAllowed);
  assign isS1SaveAllowed = ^c.s1Flags && (c.d != c.s1 || !isDSaveAllowed) &&
                           (c.cnd != c.s1 || !isCndSaveAllowed);
  assign isS0SaveAllowed = ^c.s0Flags && (c.d != c.s0 || !isDSaveAllowed) &&
                           (c.cnd != c.s0 || !isCndSaveAllowed) &&
                           (c.s1 != c.s0 || !isS1SaveAllowed);

  // cond not known yet, so treat a jump through D as taken
  assign ipFirst = !((dRegWrite && c.d == `REG_IP) || ipWriteBack);
  // a failed conditional jump still has to step the IP
  assign afterCond = (!ipWritten && isIpSaveAllowed) ? WRITE_REG_IP : operandFrom(2'd1);

  assign advance = stepDone || state == WAIT_FOR_START || state == HALTED;

  always_comb begin
    nextState = state;
    case (state)
      WAIT_FOR_START, HALTED: if (start) nextState = FETCH;
      FETCH:        nextState = PREEXECUTE;
      PREEXECUTE: begin
        if (c.op == HALT)
          nextState = HALTED;
        else if (ipFirst)
          nextState = WRITE_REG_IP;
        else
          nextState = operandFrom(2'd0);
      end
      WRITE_REG_IP: nextState = condRead ? operandFrom(2'd1) : operandFrom(2'd0);
      READ_COND:    nextState = c.cndPtr ? READ_COND_P : afterCond;
      READ_COND_P:  nextState = afterCond;
      READ_SRC1:    nextState = c.s1Ptr ? READ_SRC1_P : operandFrom(2'd2);
      READ_SRC1_P:  nextState = operandFrom(2'd2);
      READ_SRC0:    nextState = c.s0Ptr ? READ_SRC0_P : ALU_BEGIN;
      READ_SRC0_P:  nextState = ALU_BEGIN;
      ALU_BEGIN:    nextState = WRITE_PREP;
      WRITE_PREP:   nextState = writeFrom(2'd0);
      WRITE_DST, WRITE_DST_P: nextState = writeFrom(2'd1);
      WRITE_COND:   nextState = writeFrom(2'd2);
      WRITE_SRC1:   nextState = writeFrom(2'd3);
      WRITE_SRC0:   nextState = FINISH;
      FINISH:       nextState = FETCH;
      default:      nextState = WAIT_FOR_START;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= WAIT_FOR_START;
      ipWritten <= 1'b0;
      condRead <= 1'b0;
    end else if (advance) begin
      state <= nextState;
      if (state == PREEXECUTE) begin
        ipWritten <= 1'b0;
        condRead <= 1'b0;
      end
      if (state == WRITE_REG_IP)
        ipWritten <= 1'b1;
      if (state == READ_COND)
        condRead <= 1'b1;
    end
  end

endmodule

// ==== source/RegisterFile.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module RegisterFile import cpu_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  regNumT rdNum,
  output dataT   rdData,
  input  logic   wrEn,
  input  regNumT wrNum,
  input  dataT   wrData,
  output addrT   ip
);
  dataT regs [`REG_COUNT];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `REG_COUNT; i++)
        regs[i] <= (i == `REG_IP) ? dataT'(`PROG_START) : '0;
    end else if (wrEn) begin
      regs[wrNum] <= wrData;
    end
  end

  assign rdData = regs[rdNum];
  // separate read for the fetch address
  assign ip = regs[`REG_IP][`ADDR_SIZE-1:0];

endmodule

// ==== source/Alu.sv ====
`timescale 1ns/1ps

module Alu import cpu_pkg::*; (
  input  opT   op,
  input  dataT a,
  input  dataT b,
  output dataT result
);

  always_comb begin
    case (op)
      ADD:  result = a + b;
      SUB:  result = a - b;
      AND:  result = a & b;
      OR:   result = a | b;
      XOR:  result = a ^ b;
      // move s1 straight through
      PASS: result = a;
      // halt and unassigned codes
      default: result = '0;
    endcase
  end

endmodule

// ==== source/MemArbiter.sv ====
`timescale 1ns/1ps

module MemArbiter import cpu_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic hostReq,
  input  logic hostWe,
  input  addrT hostAddr,
  input  dataT hostWData,
  output logic hostGnt,
  output logic hostRdValid,
  input  logic fetchReq,
  input  logic fetchWe,
  input  addrT fetchAddr,
  input  dataT fetchWData,
  output logic fetchGnt,
  output logic fetchRdValid,
  input  logic opReq,
  input  logic opWe,
  input  addrT opAddr,
  input  dataT opWData,
  output logic opGnt,
  output logic opRdValid,
  output dataT rData,
  output logic memEn,
  output logic memWe,
  output addrT memAddr,
  output dataT memWData,
  input  dataT memRData
);
  localparam logic [1:0] OwnHost = 2'd0;
  localparam logic [1:0] OwnFetch = 2'd1;
  localparam logic [1:0] OwnOp = 2'd2;

  // busy while a read result comes back
  logic       busy;
  logic [1:0] owner;

  assign hostGnt = hostReq && !busy;
  assign fetchGnt = fetchReq && !hostReq && !busy;
  assign opGnt = opReq && !hostReq && !fetchReq && !busy;
  assign memEn = hostGnt || fetchGnt || opGnt;

  always_comb begin
    if (hostGnt) begin
      memWe = hostWe;
      memAddr = hostAddr;
      memWData = hostWData;
    end else if (fetchGnt) begin
      memWe = fetchWe;
      memAddr = fetchAddr;
      memWData = fetchWData;
    end else begin
      memWe = opGnt && opWe;
      memAddr = opAddr;
      memWData = opWData;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      owner <= OwnHost;
    end else begin
      busy <= memEn && !memWe;
      if (memEn)
        owner <= hostGnt ? OwnHost : (fetchGnt ? OwnFetch : OwnOp);
    end
  end

  assign hostRdValid = busy && owner == OwnHost;
  assign fetchRdValid = busy && owner == OwnFetch;
  assign opRdValid = busy && owner == OwnOp;
  assign rData = memRData;

endmodule

// ==== source/MainMemory.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module MainMemory import cpu_pkg::*; (
  input  logic clk,
  input  logic en,
  input  logic we,
  input  addrT addr,
  input  dataT wData,
  output dataT rData
);
  dataT mem [`MEM_DEPTH];

  // read data appears one cycle after the enable
  always_ff @(posedge clk) begin
    if (en) begin
      if (we)
        mem[addr] <= wData;
      rData <= mem[addr];
    end
  end

endmodule

// ==== source/CommandFetch.sv ====
`timescale 1ns/1ps

module CommandFetch import cpu_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  stateT state,
  input  addrT  ip,
  output logic  req,
  output addrT  addr,
  input  logic  gnt,
  input  logic  rdValid,
  input  dataT  rData,
  output dataT  command,
  output logic  stepDone
);
  // granted, waiting for the word
  logic pending;

  assign req = (state == FETCH) && !pending;
  assign addr = ip;
  assign stepDone = pending && rdValid;

  always_ff @(posedge clk) begin
    if (rst)
      pending <= 1'b0;
    else if (req && gnt)
      pending <= 1'b1;
    else if (rdValid)
      pending <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (stepDone)
      command <= rData;
  end

endmodule

// ==== source/OperandUnit.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module OperandUnit import cpu_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  stateT  state,
  input  dataT   command,
  input  logic   isIpSaveAllowed,
  input  logic   isDSaveAllowed,
  input  logic   isDSavePtrAllowed,
  input  logic   isCndSaveAllowed,
  input  logic   isS1SaveAllowed,
  input  logic   isS0SaveAllowed,
  input  dataT   aluResult,
  output regNumT rdNum,
  output logic   wrEn,
  output regNumT wrNum,
  output dataT   wrData,
  input  dataT   rdData,
  output logic   req,
  output logic   we,
  output addrT   addr,
  output dataT   wData,
  input  logic   gnt,
  input  logic   rdValid,
  input  dataT   rData,
  output dataT   cond,
  output dataT   src1,
  output dataT   src0,
  output logic   stepDone
);
  cmdT  c;
  dataT condReg;
  dataT condOrig;
  dataT s1Orig;
  dataT s0Orig;
  dataT result;
  logic memState;
  logic memActive;
  logic workState;
  logic pending;

  // post-increment or post-decrement of the value read earlier
  function automatic dataT writeBack(input dataT value, input flagsT flags);
    dataT adjusted;
    case (flags)
      2'b01:   adjusted = value + 1'b1;
      2'b10:   adjusted = value - 1'b1;
      default: adjusted = value;
    endcase
    return adjusted;
  endfunction

  assign c = cmdT'(command);
  assign memState = state inside {READ_COND_P, READ_SRC1_P, READ_SRC0_P, WRITE_DST_P};
  // failed condition drops the store
  assign memActive = memState && (state != WRITE_DST_P || isDSavePtrAllowed);
  assign workState = !(state inside {WAIT_FOR_START, FETCH, HALTED});
  assign we = (state == WRITE_DST_P);
  assign req = memActive && !pending;
  assign wData = result;
  assign stepDone = memActive ? (pending && (we || rdValid)) : workState;

  always_comb begin
    case (state)
      READ_COND_P: addr = condOrig[`ADDR_SIZE-1:0];
      READ_SRC1_P: addr = s1Orig[`ADDR_SIZE-1:0];
      READ_SRC0_P: addr = s0Orig[`ADDR_SIZE-1:0];
      default:     addr = rdData[`ADDR_SIZE-1:0];
    endcase
  end

  always_comb begin
    case (state)
      READ_COND:   rdNum = c.cnd;
      READ_SRC1:   rdNum = c.s1;
      READ_SRC0:   rdNum = c.s0;
      WRITE_DST_P: rdNum = c.d;
      default:     rdNum = regNumT'(`REG_IP);
    endcase
  end

  always_comb begin
    wrEn = 1'b0;
    wrNum = c.d;
    wrData = result;
    case (state)
      PREEXECUTE, WRITE_REG_IP: begin
        // halt still steps the IP so a restart resumes after it
        wrEn = (state == PREEXECUTE) ? (c.op == HALT) : isIpSaveAllowed;
        wrNum = regNumT'(`REG_IP);
        wrData = rdData + 1'b1;
      end
      WRITE_DST: wrEn = isDSaveAllowed;
      WRITE_COND: begin
        wrEn = isCndSaveAllowed;
        wrNum = c.cnd;
        wrData = writeBack(condOrig, c.cndFlags);
      end
      WRITE_SRC1: begin
        wrEn = isS1SaveAllowed;
        wrNum = c.s1;
        wrData = writeBack(s1Orig, c.s1Flags);
      end
      WRITE_SRC0: begin
        wrEn = isS0SaveAllowed;
        wrNum = c.s0;
        wrData = writeBack(s0Orig, c.s0Flags);
      end
      default: wrEn = 1'b0;
    endcase
  end

  // fresh value shown while the condition is being read
  always_comb begin
    cond = condReg;
    if (state == READ_COND)
      cond = rdData;
    else if (state == READ_COND_P && rdValid)
      cond = rData;
  end

  always_ff @(posedge clk) begin
    if (rst)
      pending <= 1'b0;
    else if (req && gnt)
      pending <= 1'b1;
    else if (stepDone)
      pending <= 1'b0;
  end

  always_ff @(posedge clk) begin
    case (state)
      PREEXECUTE: begin
        // unused operands read as zero
        src1 <= '0;
        src0 <= '0;
      end
      READ_COND: begin
        condReg <= rdData;
        condOrig <= rdData;
      end
      READ_COND_P: if (rdValid) condReg <= rData;
      READ_SRC1: begin
        src1 <= rdData;
        s1Orig <= rdData;
      end
      READ_SRC1_P: if (rdValid) src1 <= rData;
      READ_SRC0: begin
        src0 <= rdData;
        s0Orig <= rdData;
      end
      READ_SRC0_P: if (rdValid) src0 <= rData;
      ALU_BEGIN: result <= aluResult;
      default: result <= result;
    endcase
  end

endmodule

// ==== source/CpuCore.sv ====
`timescale 1ns/1ps

module CpuCore import cpu_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic start,
  output logic halted,
  input  logic hostReq,
  input  logic hostWe,
  input  addrT hostAddr,
  input  dataT hostWData,
  output logic hostGnt,
  output logic hostRdValid,
  output dataT hostRData
);
  stateT  state;
  cmdT    cmd;
  dataT   command, cond, src1, src0, aluResult;
  dataT   rdData, wrData, busRData, memRData, memWData, opWData;
  regNumT rdNum, wrNum;
  addrT   ip, fetchAddr, opAddr, memAddr;
  logic   wrEn, fetchReq, fetchGnt, fetchRdValid, fetchDone;
  logic   opReq, opWe, opGnt, opRdValid, opDone;
  logic   memEn, memWe;
  logic   isIpSaveAllowed, isDSaveAllowed, isDSavePtrAllowed;
  logic   isCndSaveAllowed, isS1SaveAllowed, isS0SaveAllowed;

  assign cmd = cmdT'(command);
  assign halted = (state == HALTED);
  assign hostRData = busRData;

  StateManager stateManager (
    .clk, .rst, .start, .command, .cond,
    .stepDone(fetchDone || opDone), .state,
    .isIpSaveAllowed, .isDSaveAllowed, .isDSavePtrAllowed,
    .isCndSaveAllowed, .isS1SaveAllowed, .isS0SaveAllowed
  );

  RegisterFile regFile (.clk, .rst, .rdNum, .rdData, .wrEn, .wrNum, .wrData, .ip);

  Alu alu (.op(cmd.op), .a(src1), .b(src0), .result(aluResult));

  CommandFetch commandFetch (
    .clk, .rst, .state, .ip, .req(fetchReq), .addr(fetchAddr), .gnt(fetchGnt),
    .rdValid(fetchRdValid), .rData(busRData), .command, .stepDone(fetchDone)
  );

  OperandUnit operandUnit (
    .clk, .rst, .state, .command,
    .isIpSaveAllowed, .isDSaveAllowed, .isDSavePtrAllowed,
    .isCndSaveAllowed, .isS1SaveAllowed, .isS0SaveAllowed, .aluResult,
    .rdNum, .wrEn, .wrNum, .wrData, .rdData,
    .req(opReq), .we(opWe), .addr(opAddr), .wData(opWData), .gnt(opGnt),
    .rdValid(opRdValid), .rData(busRData), .cond, .src1, .src0, .stepDone(opDone)
  );

  // fetch only ever reads
  MemArbiter memArbiter (
    .clk, .rst, .hostReq, .hostWe, .hostAddr, .hostWData, .hostGnt, .hostRdValid,
    .fetchReq, .fetchWe(1'b0), .fetchAddr, .fetchWData('0), .fetchGnt, .fetchRdValid,
    .opReq, .opWe, .opAddr, .opWData, .opGnt, .opRdValid, .rData(busRData),
    .memEn, .memWe, .memAddr, .memWData, .memRData
  );

  MainMemory mainMemory (
    .clk, .en(memEn), .we(memWe), .addr(memAddr), .wData(memWData), .rData(memRData)
  );

endmodule

// ==== tests/ClockGen.sv ====
`timescale 1ns/1ps

module ClockGen #(
  parameter int ResetCycles = 5
) (
  output logic clk,
  output logic rst
);

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // power-on reset, released on a rising edge
  initial begin
    rst = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// ==== tests/tb_CpuCore.sv ====
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tb_CpuCore import cpu_pkg::*; ();

  localparam flagsT FlagRead = 2'b00;
  localparam flagsT FlagInc = 2'b01;
  localparam flagsT FlagDec = 2'b10;
  localparam flagsT FlagNone = 2'b11;
  localparam int HostLimit = 20;
  localparam int HaltLimit = 3000;

  logic clk;
  logic porRst;
  logic testRst;
  logic rst;
  logic start;
  logic halted;
  logic hostReq;
  logic hostWe;
  addrT hostAddr;
  dataT hostWData;
  logic hostGnt;
  logic hostRdValid;
  dataT hostRData;

  int   errorCount;
  int   timeoutCount;
  dataT progWords [32];
  int   progLen;

  assign rst = porRst || testRst;

  ClockGen clockGen (.clk, .rst(porRst));

  CpuCore UUT (
    .clk, .rst, .start, .halted,
    .hostReq, .hostWe, .hostAddr, .hostWData, .hostGnt, .hostRdValid, .hostRData
  );

  // field order follows the command word, opcode in the top nibble
  function automatic dataT encodeCmd(input opT op,
      input flagsT cndF, input logic cndP, input regNumT cnd,
      input flagsT dF, input logic dP, input regNumT d,
      input flagsT s0F, input logic s0P, input regNumT s0,
      input flagsT s1F, input logic s1P, input regNumT s1);
    return {op, cndF, dF, s0F, s1F, cndP, dP, s0P, s1P, cnd, d, s0, s1};
  endfunction

  // d = mem[ptr], then ptr++
  function automatic dataT loadCmd(input regNumT d, input regNumT ptr);
    return encodeCmd(PASS, FlagNone, 0, 0, FlagRead, 0, d, FlagNone, 0, 0, FlagInc, 1, ptr);
  endfunction

  // mem[ptr] = src
  function automatic dataT storeCmd(input regNumT ptr, input regNumT src);
    return encodeCmd(PASS, FlagNone, 0, 0, FlagRead, 1, ptr, FlagNone, 0, 0, FlagRead, 0, src);
  endfunction

  function automatic dataT haltCmd();
    return encodeCmd(HALT, FlagNone, 0, 0, FlagNone, 0, 0, FlagNone, 0, 0, FlagNone, 0, 0);
  endfunction

  task automatic addCmd(input dataT word);
    progWords[progLen] = word;
    progLen++;
  endtask

  task automatic checkData(input string name, input dataT actual, input dataT expected);
    if (actual !== expected) begin
      $display("ERROR %s: got %h, expected %h", name, actual, expected);
      errorCount++;
    end
  endtask

  task automatic checkHalted(input logic expected);
    @(negedge clk);
    if (halted !== expected) begin
      $display("ERROR halted: got %h, expected %h", halted, expected);
      errorCount++;
    end
  endtask

  task automatic hostWrite(input addrT a, input dataT d);
    int   cycles;
    logic granted;
    granted = 1'b0;
    @(posedge clk);
    hostReq <= 1'b1;
    hostWe <= 1'b1;
    hostAddr <= a;
    hostWData <= d;
    for (cycles = 0; cycles < HostLimit && !granted; cycles++) begin
      @(negedge clk);
      granted = hostGnt;
    end
    // write lands on this edge
    @(posedge clk);
    hostReq <= 1'b0;
    hostWe <= 1'b0;
    if (!granted) begin
      $display("timeout: host write to address %0d was never granted", a);
      timeoutCount++;
    end
  endtask

  task automatic hostRead(input addrT a, output dataT d);
    int   cycles;
    logic granted;
    logic valid;
    granted = 1'b0;
    valid = 1'b0;
    d = 'x;
    @(posedge clk);
    hostReq <= 1'b1;
    hostWe <= 1'b0;
    hostAddr <= a;
    for (cycles = 0; cycles < HostLimit && !granted; cycles++) begin
      @(negedge clk);
      granted = hostGnt;
    end
    @(posedge clk);
    hostReq <= 1'b0;
    for (cycles = 0; cycles < HostLimit && granted && !valid; cycles++) begin
      @(negedge clk);
      valid = hostRdValid;
    end
    if (valid) begin
      d = hostRData;
    end else begin
      $display("timeout: host read of address %0d returned no data", a);
      timeoutCount++;
    end
  endtask

  task automatic expectMemory(input addrT a, input dataT expected);
    dataT word;
    hostRead(a, word);
    checkData($sformatf("mem[%0d]", a), word, expected);
  endtask

  task automatic resetCore();
    @(posedge clk);
    testRst <= 1'b1;
    repeat (5) @(posedge clk);
    testRst <= 1'b0;
    progLen = 0;
  endtask

  task automatic waitPowerOnReset();
    int cycles;
    for (cycles = 0; cycles < HostLimit && porRst !== 1'b0; cycles++)
      @(negedge clk);
    if (porRst !== 1'b0) begin
      $display("timeout: power-on reset never released");
      timeoutCount++;
    end
  endtask

  task automatic pulseStart();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic waitHalted();
    int   cycles;
    logic done;
    done = 1'b0;
    for (cycles = 0; cycles < HaltLimit && !done; cycles++) begin
      @(negedge clk);
      done = halted;
    end
    if (!done) begin
      $display("timeout: core did not halt within %0d cycles", HaltLimit);
      timeoutCount++;
    end
  endtask

  task automatic runProgram();
    int i;
    for (i = 0; i < progLen; i++)
      hostWrite(addrT'(`PROG_START + i), progWords[i]);
    pulseStart();
    waitHalted();
  endtask

  task automatic loadsAndAlu();
    dataT a;
    dataT b;
    a = $urandom();
    b = $urandom();
    resetCore();
    hostWrite(0, a);
    hostWrite(1, b);
    hostWrite(2, 16);
    addCmd(loadCmd(2, 1));
    addCmd(loadCmd(3, 1));
    // r4 is the store pointer, stepped by its own cond write-back
    addCmd(loadCmd(4, 1));
    addCmd(encodeCmd(ADD, FlagInc, 0, 4, FlagRead, 1, 4, FlagRead, 0, 3, FlagRead, 0, 2));
    addCmd(encodeCmd(SUB, FlagInc, 0, 4, FlagRead, 1, 4, FlagRead, 0, 3, FlagRead, 0, 2));
    addCmd(encodeCmd(AND, FlagInc, 0, 4, FlagRead, 1, 4, FlagRead, 0, 3, FlagRead, 0, 2));
    addCmd(encodeCmd(OR, FlagInc, 0, 4, FlagRead, 1, 4, FlagRead, 0, 3, FlagRead, 0, 2));
    addCmd(encodeCmd(XOR, FlagInc, 0, 4, FlagRead, 1, 4, FlagRead, 0, 3, FlagRead, 0, 2));
    addCmd(haltCmd());
    runProgram();
    expectMemory(16, a + b);
    expectMemory(17, a - b);
    expectMemory(18, a & b);
    expectMemory(19, a | b);
    expectMemory(20, a ^ b);
  endtask

  task automatic conditionalStore();
    dataT condVal;
    dataT srcVal;
    condVal = $urandom() | 32'h1;
    srcVal = $urandom();
    resetCore();
    hostWrite(0, 0);
    hostWrite(1, condVal);
    hostWrite(2, srcVal);
    hostWrite(3, 20);
    hostWrite(4, 21);
    hostWrite(5, 22);
    hostWrite(20, ~srcVal);
    hostWrite(21, ~srcVal);
    hostWrite(22, ~srcVal);
    addCmd(loadCmd(2, 1));
    addCmd(loadCmd(3, 1));
    addCmd(loadCmd(4, 1));
    addCmd(loadCmd(5, 1));
    addCmd(loadCmd(6, 1));
    addCmd(loadCmd(7, 1));
    // zero condition in r2, then nonzero in r3, then unconditional
    addCmd(encodeCmd(PASS, FlagRead, 0, 2, FlagRead, 1, 5, FlagNone, 0, 0, FlagRead, 0, 4));
    addCmd(encodeCmd(PASS, FlagRead, 0, 3, FlagRead, 1, 6, FlagNone, 0, 0, FlagRead, 0, 4));
    addCmd(encodeCmd(PASS, FlagNone, 0, 2, FlagRead, 1, 7, FlagNone, 0, 0, FlagRead, 0, 4));
    addCmd(haltCmd());
    runProgram();
    expectMemory(20, ~srcVal);
    expectMemory(21, srcVal);
    expectMemory(22, srcVal);
  endtask

  task automatic writeBackPriority();
    dataT x;
    dataT y;
    dataT marker;
    x = $urandom();
    y = $urandom();
    marker = $urandom();
    resetCore();
    hostWrite(0, x);
    hostWrite(1, y);
    hostWrite(2, 24);
    hostWrite(3, 30);
    hostWrite(24, marker);
    hostWrite(29, marker);
    hostWrite(30, marker);
    addCmd(loadCmd(2, 1));
    addCmd(loadCmd(3, 1));
    addCmd(loadCmd(5, 1));
    addCmd(loadCmd(7, 1));
    // D and S1 both r2, the sum must beat the increment
    addCmd(encodeCmd(ADD, FlagNone, 0, 0, FlagRead, 0, 2, FlagRead, 0, 3, FlagInc, 0, 2));
    addCmd(storeCmd(5, 2));
    // only write is r7 minus one
    addCmd(encodeCmd(PASS, FlagNone, 0, 0, FlagNone, 0, 0, FlagNone, 0, 0, FlagDec, 0, 7));
    addCmd(storeCmd(7, 2));
    addCmd(haltCmd());
    runProgram();
    expectMemory(24, x + y);
    expectMemory(29, x + y);
    expectMemory(30, marker);
  endtask

  task automatic jumpSkipsCommands();
    dataT value;
    dataT marker;
    value = $urandom();
    marker = $urandom();
    resetCore();
    hostWrite(0, `PROG_START + 6);
    hostWrite(1, 40);
    hostWrite(2, value);
    hostWrite(3, 41);
    hostWrite(40, marker);
    hostWrite(41, ~value);
    addCmd(loadCmd(2, 1));
    addCmd(loadCmd(3, 1));
    addCmd(loadCmd(4, 1));
    addCmd(encodeCmd(PASS, FlagNone, 0, 0, FlagRead, 0, regNumT'(`REG_IP),
                     FlagNone, 0, 0, FlagRead, 0, 2));
    addCmd(storeCmd(3, 4));
    addCmd(storeCmd(3, 4));
    // jump target
    addCmd(loadCmd(5, 1));
    addCmd(storeCmd(5, 4));
    addCmd(haltCmd());
    runProgram();
    expectMemory(40, marker);
    expectMemory(41, value);
  endtask

  task automatic haltAndHostAccess();
    dataT w;
    dataT hostWord;
    w = $urandom();
    hostWord = $urandom();
    resetCore();
    checkHalted(1'b0);
    hostWrite(0, w);
    hostWrite(1, 45);
    hostWrite(45, ~w);
    addCmd(haltCmd());
    addCmd(loadCmd(2, 1));
    addCmd(loadCmd(3, 1));
    addCmd(storeCmd(3, 2));
    addCmd(haltCmd());
    runProgram();
    checkHalted(1'b1);
    expectMemory(45, ~w);
    hostWrite(50, hostWord);
    expectMemory(50, hostWord);
    // resume after the first halt
    pulseStart();
    waitHalted();
    checkHalted(1'b1);
    expectMemory(45, w);
  endtask

  initial begin
    errorCount = 0;
    timeoutCount = 0;
    progLen = 0;
    testRst = 1'b0;
    start = 1'b0;
    hostReq = 1'b0;
    hostWe = 1'b0;
    hostAddr = '0;
    hostWData = '0;
    void'($urandom(32'h1285_1174));
    waitPowerOnReset();
    loadsAndAlu();
    conditionalStore();
    writeBackPriority();
    jumpSkipsCommands();
    haltAndHostAccess();
    $display("summary: %0d errors, %0d timeouts", errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
+incdir+source
source/cpu_pkg.sv
source/StateManager.sv
source/RegisterFile.sv
source/Alu.sv
source/MemArbiter.sv
source/MainMemory.sv
source/CommandFetch.sv
source/OperandUnit.sv
source/CpuCore.sv
tests/ClockGen.sv
tests/tb_CpuCore.sv

// ==== Bender.yml ====
package:
  name: cpu_core

export_include_dirs:
  - source

sources:
  - files:
      - source/cpu_pkg.sv
      - source/StateManager.sv
      - source/RegisterFile.sv
      - source/Alu.sv
      - source/MemArbiter.sv
      - source/MainMemory.sv
      - source/CommandFetch.sv
      - source/OperandUnit.sv
      - source/CpuCore.sv
  - target: test
    files:
      - tests/ClockGen.sv
      - tests/tb_CpuCore.sv
